/* verilog/proj_pkg.sv */
package proj_pkg;

    // Camera-space values are signed Q3.14.
    localparam int COORD_WIDTH = 18;
    localparam int FRAC_BITS   = 14;

    localparam int NDC_WIDTH = 17; // Signed quotient, magnitude below 2**16.
    localparam int PIX_WIDTH = 11; // Unsigned screen coordinate.

    typedef struct packed {
        logic signed [COORD_WIDTH-1:0] x;
        logic signed [COORD_WIDTH-1:0] y;
        logic signed [COORD_WIDTH-1:0] z;
    } vertex_t;

    typedef struct packed {
        logic signed [NDC_WIDTH-1:0]   x;
        logic signed [NDC_WIDTH-1:0]   y;
        logic signed [COORD_WIDTH-1:0] z; // Depth, carried unchanged.
    } ndc_t;

    typedef struct packed {
        logic [PIX_WIDTH-1:0]          px;
        logic [PIX_WIDTH-1:0]          py;
        logic signed [COORD_WIDTH-1:0] depth;
    } pixel_t;

endpackage

/* verilog/fixed_point_div.sv */
module fixed_point_div import proj_pkg::*; (
    input  logic                          clk_in,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic signed [COORD_WIDTH-1:0] numer,
    input  logic signed [COORD_WIDTH-1:0] denom,
    output logic                          busy,
    output logic                          done,
    output logic signed [NDC_WIDTH-1:0]   quotient,
    output logic                          overflow
);

    localparam int DVD_WIDTH = COORD_WIDTH + FRAC_BITS; // Numerator scaled by 2**FRAC_BITS.
    localparam int HI_WIDTH  = DVD_WIDTH - NDC_WIDTH;
    localparam int CNT_WIDTH = $clog2(NDC_WIDTH);
    localparam logic [CNT_WIDTH-1:0] LAST_STEP = CNT_WIDTH'(NDC_WIDTH - 1);

    logic [COORD_WIDTH-1:0] numer_mag;
    logic [COORD_WIDTH-1:0] denom_mag;
    logic [DVD_WIDTH-1:0]   dividend;
    logic [HI_WIDTH-1:0]    dvd_high;
    logic                   high_ovf;

    logic [COORD_WIDTH-1:0] divisor_q;
    logic [COORD_WIDTH-1:0] rem_q;
    logic [NDC_WIDTH-1:0]   dvd_q;     // Low dividend bits, consumed MSB first.
    logic [NDC_WIDTH-1:0]   quo_q;
    logic                   neg_q;
    logic                   ovf_q;
    logic [CNT_WIDTH-1:0]   step_q;

    logic [COORD_WIDTH:0]   rem_shift;
    logic [COORD_WIDTH:0]   rem_diff;
    logic                   quo_bit;
    logic [COORD_WIDTH-1:0] rem_next;
    logic [NDC_WIDTH-1:0]   quo_next;
    logic                   last_step;

    assign numer_mag = $unsigned(numer[COORD_WIDTH-1] ? -numer : numer);
    assign denom_mag = $unsigned(denom[COORD_WIDTH-1] ? -denom : denom);

    assign dividend = {numer_mag, {FRAC_BITS{1'b0}}};
    assign dvd_high = dividend[DVD_WIDTH-1 -: HI_WIDTH];

    // Quotient would need bits above the loop range; also catches a zero divisor.
    assign high_ovf = COORD_WIDTH'(dvd_high) >= denom_mag;

    assign rem_shift = {rem_q, dvd_q[NDC_WIDTH-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign quo_bit   = !rem_diff[COORD_WIDTH]; // No borrow, divisor fits.
    assign rem_next  = quo_bit ? rem_diff[COORD_WIDTH-1:0] : rem_shift[COORD_WIDTH-1:0];
    assign quo_next  = {quo_q[NDC_WIDTH-2:0], quo_bit};
    assign last_step = (step_q == LAST_STEP);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            step_q <= '0;
        end else if (!busy) begin
            if (start) begin
                busy   <= 1'b1;
                step_q <= '0;
            end
        end else if (done) begin
            busy <= 1'b0; // Free again one cycle after done.
            done <= 1'b0;
        end else begin
            step_q <= step_q + 1'b1;
            done   <= last_step;
        end
    end

    always_ff @(posedge clk_in) begin
        if (start && !busy) begin
            divisor_q <= denom_mag;
            rem_q     <= COORD_WIDTH'(dvd_high);
            dvd_q     <= dividend[NDC_WIDTH-1:0];
            quo_q     <= '0;
            neg_q     <= numer[COORD_WIDTH-1] ^ denom[COORD_WIDTH-1];
            ovf_q     <= high_ovf;
        end else if (busy && !done) begin
            rem_q <= rem_next;
            dvd_q <= dvd_q << 1;
            quo_q <= quo_next;
            if (last_step) begin
                // Magnitude must also fit NDC_WIDTH-1 bits once the sign is applied.
                quotient <= neg_q ? -quo_next : quo_next;
                overflow <= ovf_q | quo_next[NDC_WIDTH-1];
            end
        end
    end

endmodule

/* verilog/perspective_divide.sv */
module perspective_divide import proj_pkg::*; (
    input  logic    clk_in,
    input  logic    arst_n,
    input  logic    vertex_valid,
    input  vertex_t vertex,
    output logic    busy,
    output logic    ndc_valid,
    output ndc_t    ndc
);

    localparam logic signed [NDC_WIDTH-1:0] ONE = NDC_WIDTH'(2 ** FRAC_BITS);

    logic z_positive;
    logic accept;

    logic x_busy;
    logic y_busy;
    logic x_done;
    logic y_done;
    logic x_ovf;
    logic y_ovf;
    logic signed [NDC_WIDTH-1:0] x_quo;
    logic signed [NDC_WIDTH-1:0] y_quo;

    logic signed [COORD_WIDTH-1:0] depth_q;
    logic result_done;
    logic keep;

    // Strictly inside the normalized square.
    function automatic logic in_square(input logic signed [NDC_WIDTH-1:0] q);
        return (q > -ONE) && (q < ONE);
    endfunction

    assign z_positive = !vertex.z[COORD_WIDTH-1] && (vertex.z != '0);
    assign accept     = vertex_valid && !busy && z_positive; // Others are dropped here.

    fixed_point_div x_div (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .start    (accept),
        .numer    (vertex.x),
        .denom    (vertex.z),
        .busy     (x_busy),
        .done     (x_done),
        .quotient (x_quo),
        .overflow (x_ovf)
    );

    fixed_point_div y_div (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .start    (accept),
        .numer    (vertex.y),
        .denom    (vertex.z),
        .busy     (y_busy),
        .done     (y_done),
        .quotient (y_quo),
        .overflow (y_ovf)
    );

    assign busy        = x_busy || y_busy;
    assign result_done = x_done && y_done; // Both run in lockstep.
    assign keep        = !x_ovf && !y_ovf && in_square(x_quo) && in_square(y_quo);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            ndc_valid <= 1'b0;
        end else begin
            ndc_valid <= result_done && keep;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            depth_q <= vertex.z;
        end
        if (result_done && keep) begin
            ndc.x <= x_quo;
            ndc.y <= y_quo;
            ndc.z <= depth_q;
        end
    end

endmodule

/* verilog/viewport_map.sv */
module viewport_map import proj_pkg::*; #(
    parameter int VIEWPORT_W = 640,
    parameter int VIEWPORT_H = 480
) (
    input  logic   clk_in,
    input  logic   arst_n,
    input  logic   ndc_valid,
    input  ndc_t   ndc,
    output logic   pixel_valid,
    output pixel_t pixel
);

    localparam int SUM_WIDTH  = NDC_WIDTH + 1;
    localparam int PROD_WIDTH = NDC_WIDTH + PIX_WIDTH + 2;
    localparam logic signed [SUM_WIDTH-1:0] ONE = SUM_WIDTH'(2 ** FRAC_BITS);

    logic signed [SUM_WIDTH-1:0]  x_off;  // Range 0 to 2 in Q.14.
    logic signed [SUM_WIDTH-1:0]  y_off;
    logic signed [PROD_WIDTH-1:0] x_prod;
    logic signed [PROD_WIDTH-1:0] y_prod;
    logic [PIX_WIDTH-1:0]         px;
    logic [PIX_WIDTH-1:0]         py;

    assign x_off = ONE + SUM_WIDTH'(ndc.x);
    assign y_off = ONE - SUM_WIDTH'(ndc.y); // Row zero at the top of the screen.

    assign x_prod = PROD_WIDTH'(x_off) * PROD_WIDTH'(VIEWPORT_W);
    assign y_prod = PROD_WIDTH'(y_off) * PROD_WIDTH'(VIEWPORT_H);

    // Drop the fraction and the factor of two from the 0..2 offset.
    assign px = x_prod[FRAC_BITS+1 +: PIX_WIDTH];
    assign py = y_prod[FRAC_BITS+1 +: PIX_WIDTH];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= ndc_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (ndc_valid) begin
            pixel.px    <= px;
            pixel.py    <= py;
            pixel.depth <= ndc.z;
        end
    end

endmodule

/* verilog/projection_top.sv */
module projection_top import proj_pkg::*; #(
    parameter int VIEWPORT_W = 640,
    parameter int VIEWPORT_H = 480
) (
    input  logic    clk_in,
    input  logic    arst_n,
    input  logic    vertex_valid,
    input  vertex_t vertex,
    output logic    busy,
    output logic    pixel_valid,
    output pixel_t  pixel
);

    logic ndc_valid;
    ndc_t ndc;

    // 19 cycles to ndc_valid.
    perspective_divide u_perspective_divide (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .vertex_valid (vertex_valid),
        .vertex       (vertex),
        .busy         (busy),
        .ndc_valid    (ndc_valid),
        .ndc          (ndc)
    );

    viewport_map #(
        .VIEWPORT_W (VIEWPORT_W),
        .VIEWPORT_H (VIEWPORT_H)
    ) u_viewport_map (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .ndc_valid   (ndc_valid),
        .ndc         (ndc),
        .pixel_valid (pixel_valid),
        .pixel       (pixel)
    );

endmodule

/* dv/projection_tb.sv */
module projection_tb import proj_pkg::*; ();

    localparam int VIEWPORT_W     = 640;
    localparam int VIEWPORT_H     = 480;
    localparam int NUM_DIRECTED   = 15;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_ROWS       = NUM_DIRECTED + NUM_RANDOM;
    localparam int ROW_CYCLES     = 24;
    localparam int PIXEL_LATENCY  = 20;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_CYCLES + 100;
    localparam int unsigned RAND_SEED = 32'h869f_4c36;

    localparam longint ONE_Q     = longint'(1) << FRAC_BITS;
    localparam longint OVF_LIMIT = longint'(1) << (NDC_WIDTH - 1);

    // Sent one cycle after an accepted vertex and ignored by the DUT.
    localparam vertex_t ALT_VERTEX = {COORD_WIDTH'(8192), COORD_WIDTH'(4096), COORD_WIDTH'(32768)};

    typedef struct packed {
        vertex_t                       v;
        logic                          dup;          // Follow with ALT_VERTEX while busy.
        logic                          expect_pixel;
        logic [PIX_WIDTH-1:0]          px;
        logic [PIX_WIDTH-1:0]          py;
        logic signed [COORD_WIDTH-1:0] depth;
    } row_t;

    logic    clk_in = 1'b0;
    logic    arst_n;
    logic    vertex_valid;
    vertex_t vertex;
    logic    busy;
    logic    pixel_valid;
    pixel_t  pixel;

    row_t rows [NUM_ROWS];
    int   expected_pulses;
    int   pulse_count;
    int   cycle_count;

    projection_top #(
        .VIEWPORT_W (VIEWPORT_W),
        .VIEWPORT_H (VIEWPORT_H)
    ) uut (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .vertex_valid (vertex_valid),
        .vertex       (vertex),
        .busy         (busy),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel)
    );

    always #5 clk_in = ~clk_in;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    function automatic longint magnitude(input longint a);
        return (a < 0) ? -a : a;
    endfunction

    // Truncates toward zero with the sign taken as the xor of the operand signs.
    function automatic longint divide_ratio(input longint num, input longint den);
        longint mag;
        mag = (magnitude(num) << FRAC_BITS) / magnitude(den);
        return ((num < 0) != (den < 0)) ? -mag : mag;
    endfunction

    function automatic row_t model_row(input vertex_t v);
        row_t   r;
        longint qx;
        longint qy;
        logic   ovf;
        r       = '0;
        r.v     = v;
        r.depth = v.z;
        if (v.z > 0) begin
            qx  = divide_ratio(longint'(v.x), longint'(v.z));
            qy  = divide_ratio(longint'(v.y), longint'(v.z));
            ovf = (magnitude(qx) >= OVF_LIMIT) || (magnitude(qy) >= OVF_LIMIT);
            if (!ovf && magnitude(qx) < ONE_Q && magnitude(qy) < ONE_Q) begin
                r.expect_pixel = 1'b1;
                r.px = PIX_WIDTH'(((qx + ONE_Q) * VIEWPORT_W) >>> (FRAC_BITS + 1));
                r.py = PIX_WIDTH'(((ONE_Q - qy) * VIEWPORT_H) >>> (FRAC_BITS + 1));
            end
        end
        return r;
    endfunction

    function automatic row_t directed_row(input int x, input int y, input int z, input bit keep,
                                          input int px, input int py, input bit dup);
        row_t r;
        r.v.x          = COORD_WIDTH'(x);
        r.v.y          = COORD_WIDTH'(y);
        r.v.z          = COORD_WIDTH'(z);
        r.dup          = dup;
        r.expect_pixel = keep;
        r.px           = PIX_WIDTH'(px);
        r.py           = PIX_WIDTH'(py);
        r.depth        = COORD_WIDTH'(z);
        return r;
    endfunction

    task automatic fill_rows();
        vertex_t v;
        // Coordinates are raw Q3.14, so 16384 is 1.0.
        rows[0]  = directed_row(0, 0, 16384, 1'b1, 320, 240, 1'b0);    // Optical axis.
        rows[1]  = directed_row(8192, 4096, 16384, 1'b1, 480, 180, 1'b0);
        rows[2]  = directed_row(16384, -16384, 32768, 1'b1, 480, 360, 1'b0);
        // Inexact ratios where floor and truncation land on different pixels.
        rows[3]  = directed_row(4097, 5120, 16385, 1'b1, 400, 165, 1'b0);
        rows[4]  = directed_row(-4097, 5120, 16385, 1'b1, 240, 165, 1'b0);
        rows[5]  = directed_row(4097, -5120, 16385, 1'b1, 400, 314, 1'b0);
        rows[6]  = directed_row(-4097, -5120, 16385, 1'b1, 240, 314, 1'b0);
        rows[7]  = directed_row(4096, 4096, 0, 1'b0, 0, 0, 1'b0);      // Zero depth.
        rows[8]  = directed_row(0, 0, -16384, 1'b0, 0, 0, 1'b0);       // Behind camera.
        rows[9]  = directed_row(16384, 0, 16384, 1'b0, 0, 0, 1'b0);    // Ratio +1.
        rows[10] = directed_row(0, -16384, 16384, 1'b0, 0, 0, 1'b0);   // Ratio -1.
        rows[11] = directed_row(131071, 0, 1, 1'b0, 0, 0, 1'b0);       // Divider overflow.
        rows[12] = directed_row(0, -131072, 2, 1'b0, 0, 0, 1'b0);
        rows[13] = directed_row(16383, -16383, 16384, 1'b1, 639, 479, 1'b0); // Last column and row.
        rows[14] = directed_row(0, 0, 16384, 1'b1, 320, 240, 1'b1);
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            v.x     = COORD_WIDTH'($urandom);
            v.y     = COORD_WIDTH'($urandom);
            v.z     = COORD_WIDTH'($urandom_range(1, (1 << 17) - 1));
            rows[i] = model_row(v);
        end
        expected_pulses = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].expect_pixel) begin
                expected_pulses++;
            end
        end
    endtask

    always @(negedge clk_in) begin
        if (arst_n && pixel_valid) begin
            pulse_count <= pulse_count + 1;
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        int r;
        int c;
        arst_n       = 1'b0;
        vertex_valid = 1'b0;
        vertex       = '0;
        pulse_count  = 0;
        cycle_count  = 0;
        void'($urandom(RAND_SEED));
        fill_rows();

        repeat (10) @(posedge clk_in);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk_in);

        for (r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_in);
            vertex       <= rows[r].v;
            vertex_valid <= 1'b1;
            for (c = 1; c <= PIXEL_LATENCY; c++) begin
                @(posedge clk_in);
                if (c == 1 && rows[r].dup) begin
                    vertex <= ALT_VERTEX;
                    @(negedge clk_in);
                    check_value("busy", 32'(busy), 32'd1);
                end else if (c <= 2) begin
                    vertex_valid <= 1'b0;
                end
            end
            @(negedge clk_in);
            check_value("pixel_valid", 32'(pixel_valid), 32'(rows[r].expect_pixel));
            if (rows[r].expect_pixel) begin
                check_value("px", 32'(pixel.px), 32'(rows[r].px));
                check_value("py", 32'(pixel.py), 32'(rows[r].py));
                check_value("depth", 32'(pixel.depth), 32'(rows[r].depth));
            end
            repeat (ROW_CYCLES - PIXEL_LATENCY - 1) @(posedge clk_in);
        end

        repeat (4) @(posedge clk_in);
        check_value("pixel_valid pulse count", 32'(pulse_count), 32'(expected_pulses));
        $display("test passed");
        $finish;
    end

endmodule

/* src.f */
verilog/proj_pkg.sv
verilog/fixed_point_div.sv
verilog/perspective_divide.sv
verilog/viewport_map.sv
verilog/projection_top.sv
dv/projection_tb.sv

/* Makefile */
# Verilator build and run for the projection stage.

VERILATOR  ?= verilator
TOP        ?= projection_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^test passed$$" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
